//--- flist.f
+incdir+rtl
rtl/resp_pkg.sv
rtl/fifo_rd_if.sv
rtl/response_ingress.sv
rtl/response_fifo.sv
rtl/response_demux.sv
rtl/response_arbiter_top.sv
tb/tb_checker.sv
tb/tb_top.sv

//--- rtl/arb_params.svh
// Sizing for the 1-to-N distributor; ARB_FIFO_DEPTH must be a power of two
`ifndef ARB_PARAMS_SVH
`define ARB_PARAMS_SVH

// ------------------------------
// Receiver side
// ------------------------------
// One destination bit per receiver
`define ARB_NUM_RECEIVERS 4

// ------------------------------
// Response buffer
// ------------------------------
`define ARB_FIFO_DEPTH 16
// Leaves 4 free entries to absorb responses already in flight
`define ARB_PROG_THRESH 12

// ------------------------------
// Payload fields
// ------------------------------
`define ARB_DATA_W 32
`define ARB_TAG_W 8

`endif

//--- rtl/fifo_rd_if.sv
// FWFT read port; valid is simply the inverse of empty, dout is stale when empty
`timescale 1ns/1ps

interface fifo_rd_if #(
  parameter type payload_t = resp_pkg::resp_payload_t
);

  // Pop request from the consumer
  logic     rd_en;
  logic     empty;
  logic     valid;
  // Head entry, shown before it is popped
  payload_t dout;

  modport fifo (
    input  rd_en,
    output empty,
    output valid,
    output dout
  );

  modport demux (
    output rd_en,
    input  empty,
    input  valid,
    input  dout
  );

endinterface : fifo_rd_if

//--- rtl/resp_pkg.sv
// Response types for the distributor; widths come from arb_params.svh
package resp_pkg;

`include "arb_params.svh"

  // ------------------------------
  // Field types
  // ------------------------------
  // Bit i set means receiver i must see the response
  typedef logic [`ARB_NUM_RECEIVERS-1:0] dest_mask_t;

  typedef logic [`ARB_TAG_W-1:0] tag_t;

  typedef logic [`ARB_DATA_W-1:0] data_t;

  // ------------------------------
  // Response payload
  // ------------------------------
  // Mask sits in the top bits, 44 bits in all with the default sizes
  typedef struct packed {
    dest_mask_t dest;
    tag_t       tag;
    data_t      data;
  } resp_payload_t;

endpackage : resp_pkg

//--- rtl/response_arbiter_top.sv
// Sender must stop on fifo_prog_full; a receiver keeps rd_en high while it can take data
`timescale 1ns/1ps

`include "arb_params.svh"

module response_arbiter_top (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  // Sender side
  input  logic                          response_in_valid,
  input  resp_pkg::resp_payload_t       response_in_payload,
  output logic                          fifo_prog_full,
  // Receiver side
  input  logic [`ARB_NUM_RECEIVERS-1:0] rd_en,
  output logic [`ARB_NUM_RECEIVERS-1:0] response_out_valid,
  output resp_pkg::resp_payload_t       response_out_payload
);

  import resp_pkg::*;

  // ------------------------------
  // Internal connections
  // ------------------------------
  logic          fifo_wr_en;
  resp_payload_t fifo_din;

  fifo_rd_if #(
    .payload_t(resp_payload_t)
  ) fifo_rd ();

  // ------------------------------
  // Input filter
  // ------------------------------
  response_ingress u_ingress (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .in_valid      (response_in_valid),
    .in_payload    (response_in_payload),
    .fifo_wr_en    (fifo_wr_en),
    .fifo_din      (fifo_din)
  );

  // ------------------------------
  // Response buffer
  // ------------------------------
  response_fifo #(
    .payload_t  (resp_payload_t),
    .DEPTH      (`ARB_FIFO_DEPTH),
    .PROG_THRESH(`ARB_PROG_THRESH)
  ) u_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en         (fifo_wr_en),
    .din           (fifo_din),
    .prog_full     (fifo_prog_full),
    .rd            (fifo_rd.fifo)
  );

  // ------------------------------
  // Distribution to receivers
  // ------------------------------
  response_demux u_demux (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .rd_en         (rd_en),
    .out_valid     (response_out_valid),
    .out_payload   (response_out_payload),
    .rd            (fifo_rd.demux)
  );

endmodule : response_arbiter_top

//--- rtl/response_demux.sv
// Head pops only after every addressed receiver had its registered rd_en high
`timescale 1ns/1ps

`include "arb_params.svh"

module response_demux (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  logic [`ARB_NUM_RECEIVERS-1:0] rd_en,
  output logic [`ARB_NUM_RECEIVERS-1:0] out_valid,
  output resp_pkg::resp_payload_t       out_payload,
  fifo_rd_if.demux                      rd
);

  import resp_pkg::*;

  // ------------------------------
  // Read enable and mask
  // ------------------------------
  logic [`ARB_NUM_RECEIVERS-1:0] rd_en_reg;
  dest_mask_t                    head_dest;
  dest_mask_t                    mask_int;
  dest_mask_t                    mask_reg;

  // Stale memory contents are masked off while the FIFO is empty
  assign head_dest = rd.valid ? rd.dout.dest : '0;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      rd_en_reg <= '0;
    end else begin
      rd_en_reg <= rd_en;
    end
  end

  // Receivers ready for the current head
  always_comb begin
    for (int i = 0; i < `ARB_NUM_RECEIVERS; i++) begin
      mask_int[i] = rd_en_reg[i] & head_dest[i];
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      mask_reg <= '0;
    end else begin
      mask_reg <= mask_int;
    end
  end

  // ------------------------------
  // Pop decision
  // ------------------------------
  logic match;
  logic head_take;

  // Zero masks are filtered at ingress, so a valid head never matches an idle mask
  assign match     = (mask_reg == head_dest);
  assign head_take = rd.valid & match;

  assign rd.rd_en = ~rd.empty & match;

  // ------------------------------
  // Holding register
  // ------------------------------
  logic          hold_valid;
  resp_payload_t hold_payload;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      hold_valid <= 1'b0;
    end else begin
      hold_valid <= head_take;
    end
  end

  always_ff @(posedge ap_clk) begin
    hold_payload <= rd.dout;
  end

  // ------------------------------
  // Output stage
  // ------------------------------
  // Payload is broadcast, out_valid picks the receivers that take it
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out_valid <= '0;
    end else begin
      for (int i = 0; i < `ARB_NUM_RECEIVERS; i++) begin
        out_valid[i] <= hold_payload.dest[i] & hold_valid;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    out_payload <= hold_payload;
  end

endmodule : response_demux

//--- rtl/response_fifo.sv
// FWFT sync FIFO; DEPTH must be a power of two, writes while full are dropped
`timescale 1ns/1ps

`include "arb_params.svh"

module response_fifo #(
  parameter type payload_t   = logic,
  parameter int  DEPTH       = `ARB_FIFO_DEPTH,
  parameter int  PROG_THRESH = `ARB_PROG_THRESH
) (
  input  logic           ap_clk,
  input  logic           areset_control,
  input  logic           wr_en,
  input  payload_t       din,
  output logic           prog_full,
  fifo_rd_if.fifo        rd
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  // ------------------------------
  // Storage and pointers
  // ------------------------------
  payload_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // One extra bit so that DEPTH itself fits
  logic [CNT_W-1:0] count;

  logic full;
  logic do_wr;
  logic do_rd;

  assign full  = (count == CNT_W'(DEPTH));
  assign do_wr = wr_en & ~full;
  assign do_rd = rd.rd_en & ~rd.empty;

  always_ff @(posedge ap_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // ------------------------------
  // Occupancy
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      count <= '0;
    end else begin
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Lags the occupancy by one cycle, the threshold margin covers it
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      prog_full <= 1'b0;
    end else begin
      prog_full <= (count >= CNT_W'(PROG_THRESH));
    end
  end

  // ------------------------------
  // Read side
  // ------------------------------
  // Head is visible the cycle after it lands in memory
  assign rd.empty = (count == '0);
  assign rd.valid = ~rd.empty;
  assign rd.dout  = mem[rd_ptr];

endmodule : response_fifo

//--- rtl/response_ingress.sv
// One register stage; responses with an all-zero destination mask never reach the FIFO
`timescale 1ns/1ps

module response_ingress (
  input  logic                    ap_clk,
  input  logic                    areset_control,
  input  logic                    in_valid,
  input  resp_pkg::resp_payload_t in_payload,
  output logic                    fifo_wr_en,
  output resp_pkg::resp_payload_t fifo_din
);

  import resp_pkg::*;

  // ------------------------------
  // Input register
  // ------------------------------
  logic          in_valid_reg;
  resp_payload_t in_payload_reg;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_valid_reg <= 1'b0;
    end else begin
      in_valid_reg <= in_valid;
    end
  end

  // Payload only matters while in_valid_reg is set
  always_ff @(posedge ap_clk) begin
    in_payload_reg <= in_payload;
  end

  // ------------------------------
  // Filter and FIFO write
  // ------------------------------
  logic has_dest;

  // Nobody would ever pop a response addressed to no one
  assign has_dest = |in_payload_reg.dest;

  assign fifo_wr_en = in_valid_reg & has_dest;
  assign fifo_din   = in_payload_reg;

endmodule : response_ingress

//--- tb/tb_checker.sv
// Scoreboard holds at most 512 outstanding responses per receiver; samples on the rising edge
`timescale 1ns/1ps

`include "arb_params.svh"

module tb_checker (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  logic                          in_valid,
  input  resp_pkg::resp_payload_t       in_payload,
  input  resp_pkg::dest_mask_t          exp_mask,
  input  logic [`ARB_NUM_RECEIVERS-1:0] out_valid,
  input  resp_pkg::resp_payload_t       out_payload,
  input  logic                          prog_full,
  output int                            error_count,
  output int                            pending
);

  import resp_pkg::*;

  localparam int NUM   = `ARB_NUM_RECEIVERS;
  localparam int SLOTS = 512;

  // ------------------------------
  // Per-receiver expected lists
  // ------------------------------
  resp_payload_t exp_mem [NUM][SLOTS];
  int            wr_idx [NUM];
  int            rd_idx [NUM];
  resp_payload_t exp_resp;
  // Accepted responses not yet seen at any output
  int            in_flight;
  bit            was_reset;

  // Compare one receiver's output with the oldest entry it still expects
  task automatic check_output(input int r);
    if (rd_idx[r] == wr_idx[r]) begin
      error_count++;
      $display("Fail at %0t: receiver %0d got tag %h while expecting nothing",
               $time, r, out_payload.tag);
    end else begin
      exp_resp = exp_mem[r][rd_idx[r] % SLOTS];
      rd_idx[r]++;
      pending--;
      if (out_payload.tag !== exp_resp.tag || out_payload.data !== exp_resp.data ||
          out_payload.dest !== exp_resp.dest) begin
        error_count++;
        $display("Fail at %0t: receiver %0d got dest %b tag %h data %h, expected %b %h %h",
                 $time, r, out_payload.dest, out_payload.tag, out_payload.data,
                 exp_resp.dest, exp_resp.tag, exp_resp.data);
      end
    end
  endtask

  // ------------------------------
  // Monitor
  // ------------------------------
  always @(posedge ap_clk) begin
    if (areset_control) begin
      for (int r = 0; r < NUM; r++) begin
        wr_idx[r] = 0;
        rd_idx[r] = 0;
      end
      pending   = 0;
      in_flight = 0;
      // Outputs are only defined once the first reset edge has passed
      if (was_reset && out_valid !== '0) begin
        error_count++;
        $display("Fail at %0t: response_out_valid is %b during reset", $time, out_valid);
      end
      was_reset = 1'b1;
    end else begin
      was_reset = 1'b0;
      // Each FIFO entry behind the lagging status is still counted in flight
      if (prog_full === 1'b1 && in_flight < `ARB_PROG_THRESH) begin
        error_count++;
        $display("Fail at %0t: fifo_prog_full high with %0d responses in flight",
                 $time, in_flight);
      end
      for (int r = 0; r < NUM; r++) begin
        if (out_valid[r] === 1'b1) begin
          check_output(r);
        end else if (out_valid[r] !== 1'b0) begin
          error_count++;
          $display("Fail at %0t: response_out_valid[%0d] is unknown", $time, r);
        end
      end
      // One response leaves per output cycle
      if (|out_valid) begin
        in_flight--;
      end
      // Accepted input goes to every receiver the reference names
      if (in_valid) begin
        if (exp_mask != '0) begin
          in_flight++;
        end
        for (int r = 0; r < NUM; r++) begin
          if (exp_mask[r]) begin
            exp_mem[r][wr_idx[r] % SLOTS] = in_payload;
            wr_idx[r]++;
            pending++;
          end
        end
      end
    end
  end

endmodule : tb_checker

//--- tb/tb_top.sv
// Sender honors fifo_prog_full except in the fill test; run length is bounded by a cycle limit
`timescale 1ns/1ps

`include "arb_params.svh"

module tb_top;

  import resp_pkg::*;

  localparam int NUM        = `ARB_NUM_RECEIVERS;
  localparam int N_SINGLE   = 16;
  localparam int N_MULTI    = 16;
  localparam int N_DROP     = 18;
  localparam int N_RANDOM   = 64;
  localparam int N_FILL_MAX = 32;
  localparam int TOTAL_RESPONSES = N_SINGLE + N_MULTI + N_DROP + N_RANDOM + N_FILL_MAX;
  localparam int TIMEOUT_CYCLES  = TOTAL_RESPONSES * 40 + 500;

  logic            ap_clk;
  logic            areset_control;
  logic            response_in_valid;
  resp_payload_t   response_in_payload;
  logic [NUM-1:0]  rd_en;
  logic [NUM-1:0]  response_out_valid;
  resp_payload_t   response_out_payload;
  logic            fifo_prog_full;

  dest_mask_t      exp_mask;
  int              error_count;
  int              pending;
  // 0 all high, 1 all low, 2 random with stalls
  int              rd_mode;
  int              stall_left [NUM];
  int              cycle_count;
  int              tests_failed;
  int              errors_at_start;
  logic [7:0]      next_tag;
  logic            stopped_on_full;

  // ------------------------------
  // Reference model
  // ------------------------------
  // Receivers that must see the response; zero means it is dropped
  function automatic dest_mask_t expected_receivers(input resp_payload_t p);
    return p.dest;
  endfunction

  assign exp_mask = expected_receivers(response_in_payload);

  response_arbiter_top DUT (
    .ap_clk              (ap_clk),
    .areset_control      (areset_control),
    .response_in_valid   (response_in_valid),
    .response_in_payload (response_in_payload),
    .fifo_prog_full      (fifo_prog_full),
    .rd_en               (rd_en),
    .response_out_valid  (response_out_valid),
    .response_out_payload(response_out_payload)
  );

  tb_checker u_checker (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .in_valid      (response_in_valid),
    .in_payload    (response_in_payload),
    .exp_mask      (exp_mask),
    .out_valid     (response_out_valid),
    .out_payload   (response_out_payload),
    .prog_full     (fifo_prog_full),
    .error_count   (error_count),
    .pending       (pending)
  );

  // ------------------------------
  // Clock, receivers, timeout
  // ------------------------------
  initial ap_clk = 1'b0;
  always #4 ap_clk = ~ap_clk;

  always @(posedge ap_clk) begin
    #1;
    for (int r = 0; r < NUM; r++) begin
      case (rd_mode)
        0: rd_en[r] = 1'b1;
        1: rd_en[r] = 1'b0;
        default: begin
          if (stall_left[r] > 0) begin
            stall_left[r]--;
            rd_en[r] = 1'b0;
          end else if ($urandom_range(63, 0) == 0) begin
            // Long stretch with this receiver busy
            stall_left[r] = $urandom_range(40, 10);
            rd_en[r] = 1'b0;
          end else begin
            rd_en[r] = ($urandom_range(3, 0) != 0);
          end
        end
      endcase
    end
  end

  always @(posedge ap_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles, receivers never drained", cycle_count);
      $display("Regression failed");
      $finish;
    end
  end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  task automatic step();
    @(posedge ap_clk);
    #1;
  endtask

  task automatic send_resp(input dest_mask_t dest, input bit honor_full);
    while (honor_full && fifo_prog_full) begin
      response_in_valid = 1'b0;
      step();
    end
    response_in_valid   = 1'b1;
    response_in_payload = '{dest: dest, tag: next_tag, data: $urandom};
    next_tag++;
    step();
    response_in_valid = 1'b0;
  endtask

  function automatic dest_mask_t random_multi();
    dest_mask_t m;
    m = dest_mask_t'($urandom);
    while ($countones(m) < 2) begin
      m = dest_mask_t'($urandom);
    end
    return m;
  endfunction

  task automatic begin_test();
    errors_at_start = error_count;
  endtask

  // Waits for every expected output, then idles to catch stray ones
  task automatic finish_test(input int num, input string name, input bit extra_fail);
    repeat (2) step();
    while (pending != 0) begin
      step();
    end
    repeat (12) step();
    if (error_count != errors_at_start || extra_fail) begin
      tests_failed++;
      $display("Test %0d %s: FAIL, %0d check errors", num, name, error_count - errors_at_start);
    end else begin
      $display("Test %0d %s: ok", num, name);
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    void'($urandom(32'h7997_54fc));
    areset_control      = 1'b1;
    response_in_valid   = 1'b0;
    response_in_payload = '0;
    rd_en               = '0;
    rd_mode             = 0;
    next_tag            = '0;
    tests_failed        = 0;
    stopped_on_full     = 1'b0;
    repeat (5) @(posedge ap_clk);
    #1;
    areset_control = 1'b0;

    begin_test();
    repeat (20) step();
    finish_test(1, "idle after reset", 1'b0);

    begin_test();
    for (int n = 0; n < N_SINGLE; n++) begin
      send_resp(dest_mask_t'(1 << (n % NUM)), 1'b1);
    end
    finish_test(2, "single destination", 1'b0);

    begin_test();
    for (int n = 0; n < N_MULTI; n++) begin
      send_resp(random_multi(), 1'b1);
    end
    finish_test(3, "multicast", 1'b0);

    begin_test();
    for (int n = 0; n < N_DROP; n++) begin
      send_resp((n % 3 == 1) ? dest_mask_t'(0) : random_multi(), 1'b1);
    end
    finish_test(4, "zero destination drop", 1'b0);

    begin_test();
    rd_mode = 2;
    for (int n = 0; n < N_RANDOM; n++) begin
      send_resp(dest_mask_t'($urandom), 1'b1);
    end
    finish_test(5, "random back-pressure", 1'b0);

    begin_test();
    rd_mode = 1;
    repeat (3) step();
    for (int n = 0; n < N_FILL_MAX && !stopped_on_full; n++) begin
      if (fifo_prog_full) begin
        stopped_on_full = 1'b1;
      end else begin
        send_resp(random_multi(), 1'b0);
      end
    end
    if (!stopped_on_full) begin
      $display("Test 6: fifo_prog_full never rose while all receivers were stalled");
    end
    rd_mode = 0;
    finish_test(6, "fill and release", !stopped_on_full);

    $display("Tests run: 6, tests failed: %0d, check errors: %0d", tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : tb_top
